/* Bender.yml */
package:
  name: cpu_core

sources:
  - cpu_pkg.sv
  - reg_file.sv
  - decode_stage.sv
  - execute_stage.sv
  - result_stage.sv
  - cpu_core.sv
  - target: simulation
    files:
      - tb_cpu_core.sv

/* all.f */
cpu_pkg.sv
reg_file.sv
decode_stage.sv
execute_stage.sv
result_stage.sv
cpu_core.sv
tb_cpu_core.sv

/* cpu_core.sv */
`timescale 1ns/10ps

module cpu_core
  import cpu_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  logic   inst_valid,
  input  inst_t  inst,
  output logic   wb_valid,
  output regno_t wb_regno,
  output word_t  wb_data
);

  // Register file read ports
  regno_t rs_regno;
  regno_t rt_regno;
  word_t  rs_val;
  word_t  rt_val;

  // Decode buffer
  logic     d_valid;
  op1_t     d_op1;
  op2_t     d_op2;
  word_t    d_rs_val;
  word_t    d_rt_val;
  word_t    d_imm;
  regno_t   d_rt_regno;
  regno_t   d_rd_regno;
  alu_src_t d_alu_src;
  logic     d_dst_rd;
  logic     d_mem_we;
  logic     d_reg_we;
  wr_src_t  d_wr_src;

  // Execute buffer
  logic    e_valid;
  word_t   e_alu_out;
  word_t   e_rt_val;
  regno_t  e_dst_regno;
  logic    e_mem_we;
  logic    e_reg_we;
  wr_src_t e_wr_src;

  reg_file u_reg_file (
    .clk      (clk),
    .reset    (reset),
    .rs_regno (rs_regno),
    .rt_regno (rt_regno),
    .rs_val   (rs_val),
    .rt_val   (rt_val),
    .wr_en    (wb_valid),   // Write-back also feeds the port
    .wr_regno (wb_regno),
    .wr_data  (wb_data)
  );

  decode_stage u_decode (
    .clk        (clk),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst       (inst),
    .rs_regno   (rs_regno),
    .rt_regno   (rt_regno),
    .rs_val     (rs_val),
    .rt_val     (rt_val),
    .d_valid    (d_valid),
    .d_op1      (d_op1),
    .d_op2      (d_op2),
    .d_rs_val   (d_rs_val),
    .d_rt_val   (d_rt_val),
    .d_imm      (d_imm),
    .d_rt_regno (d_rt_regno),
    .d_rd_regno (d_rd_regno),
    .d_alu_src  (d_alu_src),
    .d_dst_rd   (d_dst_rd),
    .d_mem_we   (d_mem_we),
    .d_reg_we   (d_reg_we),
    .d_wr_src   (d_wr_src)
  );

  execute_stage u_execute (
    .clk         (clk),
    .reset       (reset),
    .d_valid     (d_valid),
    .d_op1       (d_op1),
    .d_op2       (d_op2),
    .d_rs_val    (d_rs_val),
    .d_rt_val    (d_rt_val),
    .d_imm       (d_imm),
    .d_rt_regno  (d_rt_regno),
    .d_rd_regno  (d_rd_regno),
    .d_alu_src   (d_alu_src),
    .d_dst_rd    (d_dst_rd),
    .d_mem_we    (d_mem_we),
    .d_reg_we    (d_reg_we),
    .d_wr_src    (d_wr_src),
    .e_valid     (e_valid),
    .e_alu_out   (e_alu_out),
    .e_rt_val    (e_rt_val),
    .e_dst_regno (e_dst_regno),
    .e_mem_we    (e_mem_we),
    .e_reg_we    (e_reg_we),
    .e_wr_src    (e_wr_src)
  );

  result_stage u_result (
    .clk         (clk),
    .reset       (reset),
    .e_valid     (e_valid),
    .e_alu_out   (e_alu_out),
    .e_rt_val    (e_rt_val),
    .e_dst_regno (e_dst_regno),
    .e_mem_we    (e_mem_we),
    .e_reg_we    (e_reg_we),
    .e_wr_src    (e_wr_src),
    .wb_valid    (wb_valid),
    .wb_regno    (wb_regno),
    .wb_data     (wb_data)
  );

endmodule

/* cpu_pkg.sv */
package cpu_pkg;

  // Datapath widths
  localparam int WORD_BITS  = 32;
  localparam int INST_BITS  = 32;
  localparam int REGNO_BITS = 4;
  localparam int IMM_BITS   = 16;
  localparam int OP1_BITS   = 6;
  localparam int OP2_BITS   = 8;

  typedef logic [WORD_BITS-1:0]  word_t;
  typedef logic [INST_BITS-1:0]  inst_t;
  typedef logic [REGNO_BITS-1:0] regno_t;
  typedef logic [IMM_BITS-1:0]   imm_t;
  typedef logic [OP1_BITS-1:0]   op1_t;
  typedef logic [OP2_BITS-1:0]   op2_t;
  typedef logic                  alu_src_t;
  typedef logic                  wr_src_t;

  // Instruction field positions
  localparam int OP1_MSB = 31;
  localparam int OP1_LSB = 26;
  localparam int OP2_MSB = 25;
  localparam int OP2_LSB = 18;
  localparam int IMM_MSB = 23;
  localparam int IMM_LSB = 8;
  localparam int RD_MSB  = 11;
  localparam int RD_LSB  = 8;
  localparam int RS_MSB  = 7;
  localparam int RS_LSB  = 4;
  localparam int RT_MSB  = 3;
  localparam int RT_LSB  = 0;

  // Primary opcodes
  localparam op1_t OP1_ALUR = 6'b000000;
  localparam op1_t OP1_LW   = 6'b010010;
  localparam op1_t OP1_SW   = 6'b011010;
  localparam op1_t OP1_ADDI = 6'b100000;
  localparam op1_t OP1_ANDI = 6'b100100;
  localparam op1_t OP1_ORI  = 6'b100101;
  localparam op1_t OP1_XORI = 6'b100110;

  // Secondary opcodes, ALUR only
  localparam op2_t OP2_EQ   = 8'b00001000;
  localparam op2_t OP2_LT   = 8'b00001001;
  localparam op2_t OP2_LE   = 8'b00001010;
  localparam op2_t OP2_NE   = 8'b00001011;
  localparam op2_t OP2_ADD  = 8'b00100000;
  localparam op2_t OP2_AND  = 8'b00100100;
  localparam op2_t OP2_OR   = 8'b00100101;
  localparam op2_t OP2_XOR  = 8'b00100110;
  localparam op2_t OP2_SUB  = 8'b00101000;
  localparam op2_t OP2_NAND = 8'b00101100;
  localparam op2_t OP2_NOR  = 8'b00101101;
  localparam op2_t OP2_NXOR = 8'b00101110;
  localparam op2_t OP2_RSHF = 8'b00110000;
  localparam op2_t OP2_LSHF = 8'b00110001;

  // Second ALU operand
  localparam alu_src_t SRC_RT_CONT = 1'b0;
  localparam alu_src_t SRC_SXT_IMM = 1'b1;

  // Register write source
  localparam wr_src_t WR_ALU = 1'b0;
  localparam wr_src_t WR_MEM = 1'b1;

  // Storage sizes
  localparam int DMEM_WORDS   = 256;
  localparam int DMEM_IDX_MSB = 9;   // Word index within a byte address
  localparam int DMEM_IDX_LSB = 2;
  localparam int REG_WORDS    = 16;

endpackage

/* decode_stage.sv */
`timescale 1ns/10ps

module decode_stage
  import cpu_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     inst_valid,
  input  inst_t    inst,
  output regno_t   rs_regno,
  output regno_t   rt_regno,
  input  word_t    rs_val,
  input  word_t    rt_val,
  output logic     d_valid,
  output op1_t     d_op1,
  output op2_t     d_op2,
  output word_t    d_rs_val,
  output word_t    d_rt_val,
  output word_t    d_imm,
  output regno_t   d_rt_regno,
  output regno_t   d_rd_regno,
  output alu_src_t d_alu_src,
  output logic     d_dst_rd,
  output logic     d_mem_we,
  output logic     d_reg_we,
  output wr_src_t  d_wr_src
);

  op1_t     op1;
  op2_t     op2;
  imm_t     imm;
  regno_t   rd_regno;
  word_t    sxt_imm;
  alu_src_t alu_src;
  logic     dst_rd;
  logic     mem_we;
  logic     reg_we;
  wr_src_t  wr_src;

  // Field split
  assign op1      = inst[OP1_MSB:OP1_LSB];
  assign op2      = inst[OP2_MSB:OP2_LSB];
  assign imm      = inst[IMM_MSB:IMM_LSB];
  assign rd_regno = inst[RD_MSB:RD_LSB];
  assign rs_regno = inst[RS_MSB:RS_LSB];
  assign rt_regno = inst[RT_MSB:RT_LSB];

  assign sxt_imm = {{(WORD_BITS-IMM_BITS){imm[IMM_BITS-1]}}, imm};

  // Control generator, unknown op1 leaves both write enables low
  always_comb begin
    alu_src = SRC_RT_CONT;
    dst_rd  = 1'b0;
    mem_we  = 1'b0;
    reg_we  = 1'b0;
    wr_src  = WR_ALU;
    case (op1)
      OP1_ALUR: begin
        dst_rd = 1'b1;   // Writes rd
        reg_we = 1'b1;
      end
      OP1_LW: begin
        alu_src = SRC_SXT_IMM;
        reg_we  = 1'b1;
        wr_src  = WR_MEM;
      end
      OP1_SW: begin
        alu_src = SRC_SXT_IMM;
        mem_we  = 1'b1;
      end
      OP1_ADDI, OP1_ANDI, OP1_ORI, OP1_XORI: begin
        alu_src = SRC_SXT_IMM;
        reg_we  = 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      d_valid  <= 1'b0;
      d_mem_we <= 1'b0;
      d_reg_we <= 1'b0;
    end else begin
      d_valid  <= inst_valid;
      d_mem_we <= inst_valid && mem_we;   // Idle slots never write
      d_reg_we <= inst_valid && reg_we;
    end
  end

  // Payload of the decode buffer
  always_ff @(posedge clk) begin
    d_op1      <= op1;
    d_op2      <= op2;
    d_rs_val   <= rs_val;
    d_rt_val   <= rt_val;
    d_imm      <= sxt_imm;
    d_rt_regno <= rt_regno;
    d_rd_regno <= rd_regno;
    d_alu_src  <= alu_src;
    d_dst_rd   <= dst_rd;
    d_wr_src   <= wr_src;
  end

  a_one_write_kind: assert property (
    @(posedge clk) disable iff (reset) !(d_mem_we && d_reg_we));

endmodule

/* execute_stage.sv */
`timescale 1ns/10ps

module execute_stage
  import cpu_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     d_valid,
  input  op1_t     d_op1,
  input  op2_t     d_op2,
  input  word_t    d_rs_val,
  input  word_t    d_rt_val,
  input  word_t    d_imm,
  input  regno_t   d_rt_regno,
  input  regno_t   d_rd_regno,
  input  alu_src_t d_alu_src,
  input  logic     d_dst_rd,
  input  logic     d_mem_we,
  input  logic     d_reg_we,
  input  wr_src_t  d_wr_src,
  output logic     e_valid,
  output word_t    e_alu_out,
  output word_t    e_rt_val,
  output regno_t   e_dst_regno,
  output logic     e_mem_we,
  output logic     e_reg_we,
  output wr_src_t  e_wr_src
);

  word_t  op_a;
  word_t  op_b;
  word_t  alu_out;
  regno_t dst_regno;

  logic signed [WORD_BITS-1:0] a_s;
  logic signed [WORD_BITS-1:0] b_s;

  assign op_a = d_rs_val;
  assign op_b = (d_alu_src == SRC_SXT_IMM) ? d_imm : d_rt_val;
  assign a_s  = op_a;
  assign b_s  = op_b;

  assign dst_regno = d_dst_rd ? d_rd_regno : d_rt_regno;

  always_comb begin
    alu_out = '0;
    case (d_op1)
      OP1_ALUR: begin
        case (d_op2)
          OP2_EQ:   alu_out = word_t'(a_s == b_s);
          OP2_LT:   alu_out = word_t'(a_s < b_s);    // Signed compares
          OP2_LE:   alu_out = word_t'(a_s <= b_s);
          OP2_NE:   alu_out = word_t'(a_s != b_s);
          OP2_ADD:  alu_out = op_a + op_b;
          OP2_AND:  alu_out = op_a & op_b;
          OP2_OR:   alu_out = op_a | op_b;
          OP2_XOR:  alu_out = op_a ^ op_b;
          OP2_SUB:  alu_out = op_a - op_b;
          OP2_NAND: alu_out = ~(op_a & op_b);
          OP2_NOR:  alu_out = ~(op_a | op_b);
          OP2_NXOR: alu_out = op_a ~^ op_b;
          OP2_RSHF: alu_out = a_s >>> op_b;   // Full 32-bit amount, sign fill
          OP2_LSHF: alu_out = op_a << op_b;
          default:  alu_out = '0;
        endcase
      end
      OP1_LW, OP1_SW, OP1_ADDI: alu_out = op_a + op_b;   // Address or sum
      OP1_ANDI: alu_out = op_a & op_b;
      OP1_ORI:  alu_out = op_a | op_b;
      OP1_XORI: alu_out = op_a ^ op_b;
      default:  alu_out = '0;
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      e_valid  <= 1'b0;
      e_mem_we <= 1'b0;
      e_reg_we <= 1'b0;
    end else begin
      e_valid  <= d_valid;
      e_mem_we <= d_mem_we;
      e_reg_we <= d_reg_we;
    end
  end

  always_ff @(posedge clk) begin
    e_alu_out   <= alu_out;
    e_rt_val    <= d_rt_val;   // Store data for SW
    e_dst_regno <= dst_regno;
    e_wr_src    <= d_wr_src;
  end

  a_op1_known: assert property (
    @(posedge clk) disable iff (reset) d_valid |-> !$isunknown(d_op1));

endmodule

/* reg_file.sv */
`timescale 1ns/10ps

module reg_file
  import cpu_pkg::*;
(
  input  logic   clk,
  input  logic   reset,
  input  regno_t rs_regno,
  input  regno_t rt_regno,
  output word_t  rs_val,
  output word_t  rt_val,
  input  logic   wr_en,
  input  regno_t wr_regno,
  input  word_t  wr_data
);

  word_t regs [REG_WORDS];

  logic rs_hit;
  logic rt_hit;

  // Register being written this cycle is seen by the reader
  assign rs_hit = wr_en && (wr_regno == rs_regno);
  assign rt_hit = wr_en && (wr_regno == rt_regno);

  assign rs_val = rs_hit ? wr_data : regs[rs_regno];
  assign rt_val = rt_hit ? wr_data : regs[rt_regno];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < REG_WORDS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[wr_regno] <= wr_data;
    end
  end

  // Written value must be visible on the next read of that register
  property p_write_lands;
    regno_t r;
    @(posedge clk) disable iff (reset)
      (wr_en, r = wr_regno) ##1 (rs_regno == r && !(wr_en && wr_regno == r))
        |-> rs_val == $past(wr_data);
  endproperty
  a_write_lands: assert property (p_write_lands);

endmodule

/* result_stage.sv */
`timescale 1ns/10ps

module result_stage
  import cpu_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  input  logic    e_valid,
  input  word_t   e_alu_out,
  input  word_t   e_rt_val,
  input  regno_t  e_dst_regno,
  input  logic    e_mem_we,
  input  logic    e_reg_we,
  input  wr_src_t e_wr_src,
  output logic    wb_valid,
  output regno_t  wb_regno,
  output word_t   wb_data
);

  typedef logic [DMEM_IDX_MSB-DMEM_IDX_LSB:0] dmem_idx_t;

  word_t dmem [DMEM_WORDS];

  dmem_idx_t mem_idx;
  word_t     mem_rd_data;
  logic      mem_wr;

  assign mem_idx     = e_alu_out[DMEM_IDX_MSB:DMEM_IDX_LSB];
  assign mem_rd_data = dmem[mem_idx];
  assign mem_wr      = e_valid && e_mem_we;

  // Store lands on the same edge as the result buffer
  always_ff @(posedge clk) begin
    if (mem_wr) begin
      dmem[mem_idx] <= e_rt_val;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= e_valid && e_reg_we;
    end
  end

  always_ff @(posedge clk) begin
    wb_regno <= e_dst_regno;
    wb_data  <= (e_wr_src == WR_MEM) ? mem_rd_data : e_alu_out;
  end

  a_wb_valid_known: assert property (
    @(posedge clk) disable iff (reset) !$isunknown(wb_valid));

endmodule

/* tb_cpu_core.sv */
`timescale 1ns/10ps

module tb_cpu_core
  import cpu_pkg::*;
;

  logic   clk;
  logic   reset;
  logic   inst_valid;
  inst_t  inst;
  logic   wb_valid;
  regno_t wb_regno;
  word_t  wb_data;

  // Reference model state in program order
  word_t model_regs [16];
  word_t model_mem  [256];

  regno_t exp_regno [$];
  word_t  exp_data  [$];
  int     exp_cyc   [$];   // Sample edge of each pending write

  int     cyc = 0;
  int     check_cnt = 0;
  int     err_cnt = 0;
  int     test_chk0;
  int     test_err0;
  string  cur_test;
  integer seed;
  regno_t got_regno;
  word_t  got_data;
  int     got_cyc;

  op2_t alu_ops [15] = '{OP2_EQ, OP2_LT, OP2_LE, OP2_NE, OP2_ADD, OP2_AND, OP2_OR, OP2_XOR,
                         OP2_SUB, OP2_NAND, OP2_NOR, OP2_NXOR, OP2_RSHF, OP2_LSHF, 8'hff};
  op1_t logic_ops [3] = '{OP1_ANDI, OP1_ORI, OP1_XORI};

  cpu_core dut (
    .clk        (clk),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst       (inst),
    .wb_valid   (wb_valid),
    .wb_regno   (wb_regno),
    .wb_data    (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  function automatic inst_t enc_alur(input op2_t op, input regno_t rd, input regno_t rs,
                                     input regno_t rt);
    return {OP1_ALUR, op, 6'b000000, rd, rs, rt};
  endfunction

  function automatic inst_t enc_imm(input op1_t op, input imm_t imm, input regno_t rs,
                                    input regno_t rt);
    return {op, 2'b00, imm, rs, rt};
  endfunction

  function automatic word_t alur_result(input op2_t op, input word_t a, input word_t b);
    case (op)
      OP2_EQ:   return {31'b0, a == b};
      OP2_LT:   return {31'b0, $signed(a) < $signed(b)};
      OP2_LE:   return {31'b0, $signed(a) <= $signed(b)};
      OP2_NE:   return {31'b0, a != b};
      OP2_ADD:  return a + b;
      OP2_AND:  return a & b;
      OP2_OR:   return a | b;
      OP2_XOR:  return a ^ b;
      OP2_SUB:  return a - b;
      OP2_NAND: return ~(a & b);
      OP2_NOR:  return ~(a | b);
      OP2_NXOR: return ~(a ^ b);
      OP2_RSHF: return (b >= 32) ? {32{a[31]}} : word_t'($signed(a) >>> b[4:0]);
      OP2_LSHF: return (b >= 32) ? 32'h0 : a << b[4:0];
      default:  return 32'h0;
    endcase
  endfunction

  // Returns 0 when the instruction writes no register
  function automatic bit expected_write(input inst_t i, output regno_t r, output word_t d);
    word_t imm;
    word_t a;
    word_t addr;
    bit    wr;
    imm  = {{16{i[23]}}, i[23:8]};
    a    = model_regs[i[7:4]];
    addr = a + imm;
    wr   = 1'b1;
    r    = i[3:0];
    d    = '0;
    case (i[31:26])
      OP1_ALUR: begin
        r = i[11:8];
        d = alur_result(i[25:18], a, model_regs[i[3:0]]);
      end
      OP1_ADDI: d = a + imm;
      OP1_ANDI: d = a & imm;
      OP1_ORI:  d = a | imm;
      OP1_XORI: d = a ^ imm;
      OP1_LW:   d = model_mem[addr[9:2]];
      OP1_SW: begin
        model_mem[addr[9:2]] = model_regs[i[3:0]];
        wr = 1'b0;
      end
      default:  wr = 1'b0;
    endcase
    if (wr) model_regs[r] = d;
    return wr;
  endfunction

  // One instruction for one cycle and then gap idle cycles
  task automatic send(input inst_t i, input int gap);
    regno_t r;
    word_t  d;
    @(posedge clk);
    #2;
    inst_valid = 1'b1;
    inst       = i;
    if (expected_write(i, r, d)) begin
      exp_regno.push_back(r);
      exp_data.push_back(d);
      exp_cyc.push_back(cyc + 1);
    end
    repeat (gap) begin
      @(posedge clk);
      #2;
      inst_valid = 1'b0;
    end
  endtask

  // Builds a full word from ADDI, LSHF by r15 and XORI
  task automatic load_word(input regno_t r, input word_t v);
    word_t hi;
    hi = v ^ {{16{v[15]}}, v[15:0]};
    send(enc_imm(OP1_ADDI, hi[31:16], 4'd0, r), 2);
    send(enc_alur(OP2_LSHF, r, r, 4'd15), 2);
    send(enc_imm(OP1_XORI, v[15:0], r, r), 2);
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_chk0 = check_cnt;
    test_err0 = err_cnt;
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    @(posedge clk);
    #2;
    inst_valid = 1'b0;
    while (exp_regno.size() != 0 && waited < 20) begin
      @(posedge clk);
      waited++;
    end
    if (exp_regno.size() != 0) begin
      $display("Timeout in test %s: %0d write-backs never arrived", cur_test,
               exp_regno.size());
      err_cnt++;
      exp_regno.delete();
      exp_data.delete();
      exp_cyc.delete();
    end
    repeat (4) @(posedge clk);   // Room for stray write-backs
    $display("Test %s: %0d checks, %0d errors", cur_test, check_cnt - test_chk0,
             err_cnt - test_err0);
  endtask

  // Compares each write-back with the oldest pending write
  always @(negedge clk) begin
    if (!reset && wb_valid === 1'b1) begin
      if (exp_regno.size() == 0) begin
        $display("Test %s: write-back to r%0d appeared with no write pending", cur_test,
                 wb_regno);
        err_cnt++;
      end else begin
        got_regno = exp_regno.pop_front();
        got_data  = exp_data.pop_front();
        got_cyc   = exp_cyc.pop_front();
        check_cnt++;
        if (wb_regno !== got_regno) begin
          $display("CHECK FAILED %s: wb_regno expected %0d, actual %0d", cur_test,
                   got_regno, wb_regno);
          err_cnt++;
        end
        if (wb_data !== got_data) begin
          $display("CHECK FAILED %s: wb_data expected %h, actual %h", cur_test,
                   got_data, wb_data);
          err_cnt++;
        end
        if (cyc + 1 - got_cyc != 3) begin   // Write lands on the next edge
          $display("CHECK FAILED %s: latency expected 3, actual %0d", cur_test,
                   cyc + 1 - got_cyc);
          err_cnt++;
        end
      end
    end
  end

  initial begin : stimulus
    imm_t consts [8] = '{16'h0001, 16'h7fff, 16'h8000, 16'hffff,
                         16'h1234, 16'hfffd, 16'h0000, 16'ha5a5};
    imm_t imms [6];
    int   n;
    int   pick;
    seed       = 10;
    reset      = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    for (int k = 0; k < 16; k++) model_regs[k] = '0;
    for (int k = 0; k < 256; k++) model_mem[k] = '0;
    repeat (16) @(posedge clk);
    #2;
    reset = 1'b0;

    start_test("idle_after_reset");
    repeat (10) begin
      @(negedge clk);
      check_cnt++;
      if (wb_valid !== 1'b0) begin
        $display("Test %s: wb_valid was not low while no instruction was sent", cur_test);
        err_cnt++;
      end
    end
    drain();

    start_test("addi_constants");
    for (int k = 0; k < 8; k++) send(enc_imm(OP1_ADDI, consts[k], 4'd0, regno_t'(k + 1)), 0);
    drain();

    start_test("alur_random");
    send(enc_imm(OP1_ADDI, 16'd16, 4'd0, 4'd15), 0);
    send(enc_imm(OP1_ADDI, 16'd0, 4'd0, 4'd5), 0);    // Shift amounts 0, 31, 32
    send(enc_imm(OP1_ADDI, 16'd31, 4'd0, 4'd6), 0);
    send(enc_imm(OP1_ADDI, 16'd32, 4'd0, 4'd7), 2);
    load_word(4'd8, word_t'($random(seed)) | 32'h40);
    for (int round = 0; round < 2; round++) begin
      for (int k = 1; k <= 4; k++) load_word(regno_t'(k), word_t'($random(seed)));
      n = 0;
      foreach (alu_ops[j]) begin
        for (int rs = 1; rs <= 4; rs++) begin
          for (int rt = 1; rt <= 8; rt++) begin
            send(enc_alur(alu_ops[j], regno_t'(9 + n % 6), regno_t'(rs), regno_t'(rt)), 0);
            n++;
          end
        end
      end
    end
    drain();

    start_test("logic_imm");
    for (int k = 1; k <= 4; k++) load_word(regno_t'(k), word_t'($random(seed)));
    imms = '{16'h0000, 16'h7fff, 16'h8000, 16'hffff, 16'h0000, 16'h0000};
    imms[4] = imm_t'($random(seed));
    imms[5] = imm_t'($random(seed));
    n = 0;
    foreach (logic_ops[j]) begin
      for (int m = 0; m < 6; m++) begin
        for (int rs = 1; rs <= 4; rs++) begin
          send(enc_imm(logic_ops[j], imms[m], regno_t'(rs), regno_t'(9 + n % 6)), 0);
          n++;
        end
      end
    end
    drain();

    start_test("store_load");
    send(enc_imm(OP1_ADDI, 16'h0100, 4'd0, 4'd1), 0);
    for (int k = 2; k <= 5; k++) load_word(regno_t'(k), word_t'($random(seed)));
    send(enc_imm(OP1_SW, 16'h0000, 4'd1, 4'd2), 0);
    send(enc_imm(OP1_SW, 16'h0004, 4'd1, 4'd3), 0);
    send(enc_imm(OP1_SW, 16'hfff8, 4'd1, 4'd4), 0);   // Negative offset
    send(enc_imm(OP1_SW, 16'h03fc, 4'd0, 4'd5), 1);   // Last word of memory
    send(enc_imm(OP1_LW, 16'h0000, 4'd1, 4'd9), 0);
    send(enc_imm(OP1_LW, 16'h0004, 4'd1, 4'd10), 0);
    send(enc_imm(OP1_LW, 16'hfff8, 4'd1, 4'd11), 0);
    send(enc_imm(OP1_LW, 16'h03fc, 4'd0, 4'd12), 0);
    send(enc_imm(OP1_SW, 16'h0004, 4'd1, 4'd2), 1);   // Overwrite and read back
    send(enc_imm(OP1_LW, 16'h0004, 4'd1, 4'd13), 0);
    send(enc_imm(OP1_LW, 16'h0000, 4'd1, 4'd14), 0);
    drain();

    start_test("back_to_back");
    for (int k = 1; k <= 4; k++) load_word(regno_t'(k), word_t'($random(seed)));
    for (int c = 0; c < 30; c++) begin
      pick = $unsigned($random(seed)) % 5;
      case (pick)
        0: send(enc_imm(OP1_ADDI, imm_t'($random(seed)), 4'd0, regno_t'(9 + c % 6)), 0);
        1: send(enc_alur(alu_ops[$unsigned($random(seed)) % 15], regno_t'(9 + c % 6),
                         regno_t'(1 + $unsigned($random(seed)) % 8),
                         regno_t'(1 + $unsigned($random(seed)) % 8)), 0);
        2: send(enc_imm(OP1_XORI, imm_t'($random(seed)), regno_t'(1 + c % 4),
                        regno_t'(9 + c % 6)), 0);
        3: send(enc_imm(OP1_LW, (c % 2) ? 16'h0104 : 16'h03fc, 4'd0, regno_t'(9 + c % 6)), 0);
        default: send({6'b111111, 26'($random(seed))}, 0);   // Unsupported op1
      endcase
    end
    drain();

    $display("Checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule
